/* src/bus_pkg.sv */
package bus_pkg;

    //////////////////////////////////////////////////
    // Basic bus widths
    //////////////////////////////////////////////////

    // Z80 address and data bus
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // Bank number for the 512 KB external RAM (32 x 16 KB)
    typedef logic [4:0]  bank_t;

    //////////////////////////////////////////////////
    // Strobe events
    //////////////////////////////////////////////////

    // One-clock pulses derived from the synchronized rd_n and wr_n
    typedef struct packed {
        logic read_start;
        logic read_done;
        logic write_start;
        logic write_done;
    } bus_evt_t;

    //////////////////////////////////////////////////
    // Decoded selects
    //////////////////////////////////////////////////

    typedef struct packed {
        logic int_ram;
        logic reg_bank0;
        logic reg_bank1;
        logic reg_bank2;
        logic reg_ramctrl;
        logic ext_ram;
        logic io_joy1;
        logic io_joy2;
        logic io_periph;
        // Bridge drives the data bus for this cycle
        logic internal;
        // a0 of the IO address, data or control port
        logic periph_port;
    } bus_sel_t;

endpackage

/* src/map_pkg.sv */
package map_pkg;

    //////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////

    // Page 11 (0xC000-0xFFFF) is the internal RAM
    localparam logic [1:0]  int_ram_base_page = 2'b11;
    localparam int          int_ram_addr_bits = 13;

    // Bank 0 starts above the low vector area
    localparam logic [15:0] bank0_low_limit   = 16'h0400;

    // Control registers at the top of the internal RAM
    localparam logic [15:0] reg_ramctrl_addr  = 16'hFFFC;
    localparam logic [15:0] reg_bank0_addr    = 16'hFFFD;
    localparam logic [15:0] reg_bank1_addr    = 16'hFFFE;
    localparam logic [15:0] reg_bank2_addr    = 16'hFFFF;

    //////////////////////////////////////////////////
    // IO map, codes are {a7, a6, a0}
    //////////////////////////////////////////////////

    localparam logic [2:0]  io_periph_data_code = 3'b100;
    localparam logic [2:0]  io_periph_ctrl_code = 3'b101;
    localparam logic [2:0]  io_joy1_code        = 3'b110;
    localparam logic [2:0]  io_joy2_code        = 3'b111;

    // Value seen on reads of anything not decoded
    localparam logic [7:0]  unmapped_rddata     = 8'hFF;

    //////////////////////////////////////////////////
    // Bank register reset values
    //////////////////////////////////////////////////

    localparam logic [4:0]  bank0_reset = 5'd0;
    localparam logic [4:0]  bank1_reset = 5'd1;
    localparam logic [4:0]  bank2_reset = 5'd2;

endpackage

/* src/bus_strobe_sync.sv */
`timescale 1ns/1ps

module bus_strobe_sync (
    input  logic               clk,
    input  logic               reset,
    input  logic               rd_n,
    input  logic               wr_n,
    input  bus_pkg::bus_data_t d_in,
    output bus_pkg::bus_evt_t  evt,
    output bus_pkg::bus_data_t wrdata
);

    // Strobe history, bit 0 is the newest sample
    logic [2:0] rd_n_r;
    logic [2:0] wr_n_r;

    // Strobes idle high, so reset to all ones to avoid a false edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_n_r <= 3'b111;
            wr_n_r <= 3'b111;
        end else begin
            rd_n_r <= {rd_n_r[1:0], rd_n};
            wr_n_r <= {wr_n_r[1:0], wr_n};
        end
    end

    // Edge detect on the two oldest stages
    always_comb begin
        evt.read_start  = (rd_n_r[2:1] == 2'b10);
        evt.read_done   = (rd_n_r[2:1] == 2'b01);
        evt.write_start = (wr_n_r[2:1] == 2'b10);
        evt.write_done  = (wr_n_r[2:1] == 2'b01);
    end

    // Capture data for as long as the write strobe is low;
    // the last sample is stable well before write_start
    always_ff @(posedge clk) begin
        if (!wr_n) begin
            wrdata <= d_in;
        end
    end

endmodule

/* src/addr_decode.sv */
`timescale 1ns/1ps

module addr_decode (
    input  bus_pkg::bus_addr_t addr,
    input  logic               wr_n,
    input  logic               mreq_n,
    input  logic               iorq_n,
    input  logic               startup_mode,
    input  bus_pkg::bank_t     bank0,
    input  bus_pkg::bank_t     bank1,
    input  bus_pkg::bank_t     bank2,
    output bus_pkg::bus_sel_t  sel,
    output bus_pkg::bank_t     ba,
    output logic               ram_ce_n,
    output logic               ram_we_n
);

    import map_pkg::*;

    logic       mem_cycle;
    logic       io_cycle;
    logic [1:0] page;
    logic [2:0] io_code;

    assign mem_cycle = !mreq_n;
    assign io_cycle  = !iorq_n;
    assign page      = addr[15:14];
    assign io_code   = {addr[7], addr[6], addr[0]};

    //////////////////////////////////////////////////
    // Bank address for the external RAM
    //////////////////////////////////////////////////

    always_comb begin
        ba = '0;
        if (page == 2'b00 && addr >= bank0_low_limit) begin
            ba = bank0;
        end else if (page == 2'b01) begin
            ba = bank1;
        end else if (page == 2'b10) begin
            ba = bank2;
        end
    end

    //////////////////////////////////////////////////
    // Selects
    //////////////////////////////////////////////////

    always_comb begin
        sel = '0;

        // Page 11 is internal RAM; register writes also land in RAM
        sel.int_ram     = mem_cycle && (page == int_ram_base_page);
        sel.reg_ramctrl = mem_cycle && (addr == reg_ramctrl_addr);
        sel.reg_bank0   = mem_cycle && (addr == reg_bank0_addr);
        sel.reg_bank1   = mem_cycle && (addr == reg_bank1_addr);
        sel.reg_bank2   = mem_cycle && (addr == reg_bank2_addr);

        // IO space
        sel.io_joy1     = io_cycle && (io_code == io_joy1_code);
        sel.io_joy2     = io_cycle && (io_code == io_joy2_code);
        sel.io_periph   = io_cycle && (io_code == io_periph_data_code ||
                                       io_code == io_periph_ctrl_code);
        sel.periph_port = addr[0];

        sel.internal    = io_cycle || sel.int_ram;

        // External RAM is read-only once startup has finished
        sel.ext_ram     = mem_cycle && !sel.internal && (wr_n || startup_mode);
    end

    assign ram_ce_n = !sel.ext_ram;
    assign ram_we_n = !(!wr_n && sel.ext_ram && startup_mode);

endmodule

/* src/bank_regs.sv */
`timescale 1ns/1ps

module bank_regs (
    input  logic               clk,
    input  logic               reset,
    input  bus_pkg::bus_evt_t  evt,
    input  bus_pkg::bus_sel_t  sel,
    input  bus_pkg::bus_data_t wrdata,
    output bus_pkg::bank_t     bank0,
    output bus_pkg::bank_t     bank1,
    output bus_pkg::bank_t     bank2,
    output logic               startup_mode
);

    import bus_pkg::*;
    import map_pkg::*;

    // RAM control value, kept for software but not decoded here
    bus_data_t ramctrl;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank0        <= bank0_reset;
            bank1        <= bank1_reset;
            bank2        <= bank2_reset;
            ramctrl      <= '0;
            startup_mode <= 1'b1;
        end else if (evt.write_start) begin
            if (sel.reg_bank0) begin
                bank0 <= wrdata[4:0];
            end
            if (sel.reg_bank1) begin
                bank1 <= wrdata[4:0];
            end
            if (sel.reg_bank2) begin
                bank2 <= wrdata[4:0];
            end

            // First ramctrl write leaves startup mode for good
            if (sel.reg_ramctrl) begin
                ramctrl      <= wrdata;
                startup_mode <= 1'b0;
            end
        end
    end

endmodule

/* src/int_ram.sv */
`timescale 1ns/1ps

module int_ram (
    input  logic                                 clk,
    input  logic [map_pkg::int_ram_addr_bits-1:0] addr,
    input  bus_pkg::bus_data_t                   wrdata,
    input  logic                                 wren,
    output bus_pkg::bus_data_t                   rddata
);

    import bus_pkg::*;
    import map_pkg::*;

    localparam int depth = 1 << int_ram_addr_bits;

    bus_data_t mem [depth];

    // Single port, old contents come out on a write
    always_ff @(posedge clk) begin
        rddata <= mem[addr];
        if (wren) begin
            mem[addr] <= wrdata;
        end
    end

endmodule

/* src/read_mux.sv */
`timescale 1ns/1ps

module read_mux (
    input  logic               clk,
    input  logic               reset,
    input  logic               rd_n,
    input  bus_pkg::bus_sel_t  sel,
    input  bus_pkg::bus_evt_t  evt,
    input  bus_pkg::bus_data_t ram_rddata,
    input  logic [5:0]         joy1_n,
    input  bus_pkg::bus_data_t periph_rddata,
    output bus_pkg::bus_data_t d_out,
    output logic               d_oe,
    output logic               periph_wren,
    output logic               periph_wrdone,
    output logic               periph_rddone
);

    import map_pkg::*;

    logic [5:0] joy1_n_r;
    logic [5:0] joy1_n_rr;
    logic       periph_reading;
    logic       periph_writing;

    // Joystick lines are asynchronous
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            joy1_n_r  <= '1;
            joy1_n_rr <= '1;
        end else begin
            joy1_n_r  <= joy1_n;
            joy1_n_rr <= joy1_n_r;
        end
    end

    //////////////////////////////////////////////////
    // Read data
    //////////////////////////////////////////////////

    // Joystick 2 and undecoded ports read as unmapped
    always_comb begin
        d_out = unmapped_rddata;
        if (sel.int_ram) begin
            d_out = ram_rddata;
        end
        if (sel.io_periph) begin
            d_out = periph_rddata;
        end
        if (sel.io_joy1) begin
            d_out = {2'b11, joy1_n_rr};
        end
    end

    assign d_oe = !rd_n && sel.internal;

    //////////////////////////////////////////////////
    // Peripheral strobes
    //////////////////////////////////////////////////

    assign periph_wren = sel.io_periph && evt.write_start;

    // The IO select is gone by the time the strobe edge is seen,
    // so remember which cycle was ours
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            periph_reading <= 1'b0;
            periph_writing <= 1'b0;
            periph_rddone  <= 1'b0;
            periph_wrdone  <= 1'b0;
        end else begin
            periph_rddone <= 1'b0;
            periph_wrdone <= 1'b0;

            if (sel.io_periph && evt.read_start) begin
                periph_reading <= 1'b1;
            end
            if (periph_reading && evt.read_done) begin
                periph_reading <= 1'b0;
                periph_rddone  <= 1'b1;
            end

            if (sel.io_periph && evt.write_start) begin
                periph_writing <= 1'b1;
            end
            if (periph_writing && evt.write_done) begin
                periph_writing <= 1'b0;
                periph_wrdone  <= 1'b1;
            end
        end
    end

endmodule

/* src/bus_bridge_top.sv */
`timescale 1ns/1ps

module bus_bridge_top (
    input  logic               clk,
    input  logic               reset,
    input  bus_pkg::bus_addr_t addr,
    input  bus_pkg::bus_data_t d_in,
    input  logic               rd_n,
    input  logic               wr_n,
    input  logic               mreq_n,
    input  logic               iorq_n,
    input  logic [5:0]         joy1_n,
    input  bus_pkg::bus_data_t periph_rddata,
    output bus_pkg::bus_data_t d_out,
    output logic               d_oe,
    output bus_pkg::bank_t     ba,
    output logic               ram_ce_n,
    output logic               ram_we_n,
    output logic               periph_port,
    output logic               periph_wren,
    output logic               periph_wrdone,
    output logic               periph_rddone
);

    import bus_pkg::*;
    import map_pkg::*;

    bus_evt_t  evt;
    bus_sel_t  sel;
    bus_data_t wrdata;
    bus_data_t ram_rddata;
    bank_t     bank0;
    bank_t     bank1;
    bank_t     bank2;
    logic      startup_mode;
    logic      ram_wren;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    bus_strobe_sync u_strobe_sync (
        .clk    (clk),
        .reset  (reset),
        .rd_n   (rd_n),
        .wr_n   (wr_n),
        .d_in   (d_in),
        .evt    (evt),
        .wrdata (wrdata)
    );

    addr_decode u_addr_decode (
        .addr         (addr),
        .wr_n         (wr_n),
        .mreq_n       (mreq_n),
        .iorq_n       (iorq_n),
        .startup_mode (startup_mode),
        .bank0        (bank0),
        .bank1        (bank1),
        .bank2        (bank2),
        .sel          (sel),
        .ba           (ba),
        .ram_ce_n     (ram_ce_n),
        .ram_we_n     (ram_we_n)
    );

    //////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////

    bank_regs u_bank_regs (
        .clk          (clk),
        .reset        (reset),
        .evt          (evt),
        .sel          (sel),
        .wrdata       (wrdata),
        .bank0        (bank0),
        .bank1        (bank1),
        .bank2        (bank2),
        .startup_mode (startup_mode)
    );

    assign ram_wren = sel.int_ram && evt.write_start;

    int_ram u_int_ram (
        .clk    (clk),
        .addr   (addr[int_ram_addr_bits-1:0]),
        .wrdata (wrdata),
        .wren   (ram_wren),
        .rddata (ram_rddata)
    );

    //////////////////////////////////////////////////
    // Result
    //////////////////////////////////////////////////

    read_mux u_read_mux (
        .clk           (clk),
        .reset         (reset),
        .rd_n          (rd_n),
        .sel           (sel),
        .evt           (evt),
        .ram_rddata    (ram_rddata),
        .joy1_n        (joy1_n),
        .periph_rddata (periph_rddata),
        .d_out         (d_out),
        .d_oe          (d_oe),
        .periph_wren   (periph_wren),
        .periph_wrdone (periph_wrdone),
        .periph_rddone (periph_rddone)
    );

    assign periph_port = sel.periph_port;

endmodule

/* test/tb_bus_bridge.sv */
`timescale 1ns/1ps

module tb_bus_bridge;

    import map_pkg::*;

    localparam int clk_period           = 40;
    localparam int reset_cycles         = 16;
    // Lead edge, 6 clocks strobe low, 3 clocks high
    localparam int clocks_per_bus_cycle = 10;
    localparam int total_bus_cycles     = 58;
    localparam int margin_cycles        = 200;
    localparam int watchdog_ns          =
        (reset_cycles + total_bus_cycles * clocks_per_bus_cycle + margin_cycles) * clk_period;
    localparam logic [7:0] periph_byte  = 8'hA5;

    logic        clk;
    logic        reset;
    logic [15:0] addr;
    logic [7:0]  d_in;
    logic        rd_n;
    logic        wr_n;
    logic        mreq_n;
    logic        iorq_n;
    logic [5:0]  joy1_n;
    logic [7:0]  periph_rddata;
    logic [7:0]  d_out;
    logic        d_oe;
    logic [4:0]  ba;
    logic        ram_ce_n;
    logic        ram_we_n;
    logic        periph_port;
    logic        periph_wren;
    logic        periph_wrdone;
    logic        periph_rddone;

    // Outputs captured in the middle of the 5th strobe clock
    logic [7:0]  smp_d_out;
    logic        smp_d_oe;
    logic [4:0]  smp_ba;
    logic        smp_ce_n;
    logic        smp_we_n;
    logic        smp_port;
    logic [15:0] cur_addr;

    // Reference model
    logic [7:0]  ref_ram [8192];
    logic [4:0]  ref_bank [3];
    logic        ref_startup;

    int     errors = 0;
    int     bus_cycles = 0;
    int     wren_count = 0;
    int     wrdone_count = 0;
    int     rddone_count = 0;
    integer seed = 10053;

    bus_bridge_top u_dut (
        .clk           (clk),
        .reset         (reset),
        .addr          (addr),
        .d_in          (d_in),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .mreq_n        (mreq_n),
        .iorq_n        (iorq_n),
        .joy1_n        (joy1_n),
        .periph_rddata (periph_rddata),
        .d_out         (d_out),
        .d_oe          (d_oe),
        .ba            (ba),
        .ram_ce_n      (ram_ce_n),
        .ram_we_n      (ram_we_n),
        .periph_port   (periph_port),
        .periph_wren   (periph_wren),
        .periph_wrdone (periph_wrdone),
        .periph_rddone (periph_rddone)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Peripheral side pulse counters
    always @(negedge clk) begin
        if (periph_wren) begin
            wren_count <= wren_count + 1;
        end
        if (periph_wrdone) begin
            wrdone_count <= wrdone_count + 1;
        end
        if (periph_rddone) begin
            rddone_count <= rddone_count + 1;
        end
    end

    //////////////////////////////////////////////////
    // Reference model and reporting
    //////////////////////////////////////////////////

    function automatic logic [4:0] exp_ba(input logic [15:0] a);
        if (a[15:14] == 2'b00 && a >= 16'h0400) begin
            return ref_bank[0];
        end else if (a[15:14] == 2'b01) begin
            return ref_bank[1];
        end else if (a[15:14] == 2'b10) begin
            return ref_bank[2];
        end
        return 5'd0;
    endfunction

    task automatic model_write(input logic [15:0] a, input logic [7:0] data);
        if (a[15:14] == 2'b11) begin
            ref_ram[a[12:0]] = data;
        end
        if (a == 16'hFFFC) begin
            ref_startup = 1'b0;
        end else if (a >= 16'hFFFD) begin
            ref_bank[a - 16'hFFFD] = data[4:0];
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("[ERROR] %s at addr 0x%h: got 0x%0h, expected 0x%0h",
                 name, cur_addr, got, exp);
    endtask

    //////////////////////////////////////////////////
    // Bus-cycle model
    //////////////////////////////////////////////////

    task automatic bus_cycle(input logic is_io, input logic is_write,
                             input logic [15:0] a, input logic [7:0] data);
        @(posedge clk);
        #2;
        cur_addr = a;
        addr     = a;
        d_in     = data;
        mreq_n   = is_io;
        iorq_n   = !is_io;
        if (is_write) begin
            wr_n = 1'b0;
        end else begin
            rd_n = 1'b0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        smp_d_out = d_out;
        smp_d_oe  = d_oe;
        smp_ba    = ba;
        smp_ce_n  = ram_ce_n;
        smp_we_n  = ram_we_n;
        smp_port  = periph_port;
        @(posedge clk);
        #2;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        repeat (3) @(posedge clk);
        bus_cycles++;
    endtask

    task automatic mem_write(input logic [15:0] a, input logic [7:0] data);
        bus_cycle(1'b0, 1'b1, a, data);
        model_write(a, data);
    endtask

    task automatic mem_read(input logic [15:0] a);
        bus_cycle(1'b0, 1'b0, a, 8'h00);
    endtask

    task automatic io_write(input logic [15:0] a, input logic [7:0] data);
        bus_cycle(1'b1, 1'b1, a, data);
    endtask

    task automatic io_read(input logic [15:0] a);
        bus_cycle(1'b1, 1'b0, a, 8'h00);
    endtask

    task automatic check_ba_at(input logic [15:0] a);
        mem_read(a);
        if (smp_ba !== exp_ba(a)) report_mismatch("ba", 32'(smp_ba), 32'(exp_ba(a)));
    endtask

    // External RAM is written only while in startup mode
    task automatic check_ext_write(input logic [15:0] a, input logic [7:0] data);
        logic exp_strobe_n;
        exp_strobe_n = !ref_startup;
        mem_write(a, data);
        if (smp_we_n !== exp_strobe_n) begin
            report_mismatch("ram_we_n", 32'(smp_we_n), 32'(exp_strobe_n));
        end
        if (smp_ce_n !== exp_strobe_n) begin
            report_mismatch("ram_ce_n", 32'(smp_ce_n), 32'(exp_strobe_n));
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_map();
        check_ba_at(16'h0400);
        check_ba_at(16'h4000);
        check_ba_at(16'h8000);
        check_ba_at(16'h0123);
        check_ba_at(16'hC000);
        // Startup mode lets the external RAM be written
        check_ext_write(16'h8123, 8'h77);
    endtask

    task automatic test_bank_regs();
        logic [31:0] r;
        logic [15:0] a;
        for (int i = 0; i < 3; i++) begin
            r = $random(seed);
            mem_write(reg_bank0_addr + 16'(i), r[7:0]);
        end
        check_ba_at(16'h0400);
        check_ba_at(16'h4000);
        check_ba_at(16'h8000);
        // Bank 0 must stay off the low area and page 11
        check_ba_at(16'h0123);
        check_ba_at(16'hC000);
        for (int i = 0; i < 3; i++) begin
            a = reg_bank0_addr + 16'(i);
            mem_read(a);
            if (smp_d_out !== ref_ram[a[12:0]]) begin
                report_mismatch("d_out", 32'(smp_d_out), 32'(ref_ram[a[12:0]]));
            end
            if (smp_d_oe !== 1'b1) report_mismatch("d_oe", 32'(smp_d_oe), 32'h1);
        end
    endtask

    task automatic test_int_ram();
        logic [31:0] r;
        logic [15:0] addrs [16];
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            addrs[i] = 16'hC000 | (r[15:0] & 16'h3FFF);
            // Keep clear of the control registers
            if (addrs[i] >= 16'hFFFC) begin
                addrs[i] = 16'hFFF0;
            end
            mem_write(addrs[i], r[23:16]);
        end
        for (int i = 0; i < 16; i++) begin
            mem_read(addrs[i]);
            if (smp_d_out !== ref_ram[addrs[i][12:0]]) begin
                report_mismatch("d_out", 32'(smp_d_out), 32'(ref_ram[addrs[i][12:0]]));
            end
            if (smp_d_oe !== 1'b1) report_mismatch("d_oe", 32'(smp_d_oe), 32'h1);
        end
        mem_read(16'h4100);
        if (smp_d_oe !== 1'b0) report_mismatch("d_oe", 32'(smp_d_oe), 32'h0);
        if (smp_ce_n !== 1'b0) report_mismatch("ram_ce_n", 32'(smp_ce_n), 32'h0);
    endtask

    task automatic test_end_startup();
        mem_write(reg_ramctrl_addr, 8'h5A);
        check_ext_write(16'h8040, 8'h33);
        mem_read(16'h8040);
        if (smp_ce_n !== 1'b0) report_mismatch("ram_ce_n", 32'(smp_ce_n), 32'h0);
        if (smp_ba !== exp_ba(16'h8040)) report_mismatch("ba", 32'(smp_ba), 32'(ref_bank[2]));
    endtask

    task automatic test_io_space();
        int rd_before;
        int wr_before;
        int wrdone_before;
        int waited;
        @(posedge clk);
        #2;
        joy1_n = 6'h2A;
        repeat (4) @(posedge clk);
        io_read(16'h00C0);
        if (smp_d_out !== 8'hEA) report_mismatch("d_out", 32'(smp_d_out), 32'hEA);
        if (smp_d_oe !== 1'b1) report_mismatch("d_oe", 32'(smp_d_oe), 32'h1);
        io_read(16'h00C1);
        if (smp_d_out !== 8'hFF) report_mismatch("d_out", 32'(smp_d_out), 32'hFF);
        io_read(16'h0010);
        if (smp_d_out !== 8'hFF) report_mismatch("d_out", 32'(smp_d_out), 32'hFF);

        // Peripheral data port read
        rd_before = rddone_count;
        io_read(16'h0080);
        if (smp_d_out !== periph_byte) report_mismatch("d_out", 32'(smp_d_out), 32'(periph_byte));
        if (smp_port !== 1'b0) report_mismatch("periph_port", 32'(smp_port), 32'h0);
        waited = 0;
        while (rddone_count == rd_before && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (rddone_count == rd_before) begin
            errors++;
            $display("periph_rddone never pulsed after the peripheral read");
        end

        // Peripheral control port write
        wr_before     = wren_count;
        wrdone_before = wrdone_count;
        io_write(16'h0081, 8'h3C);
        if (smp_port !== 1'b1) report_mismatch("periph_port", 32'(smp_port), 32'h1);
        waited = 0;
        while (wrdone_count == wrdone_before && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (wrdone_count == wrdone_before) begin
            errors++;
            $display("periph_wrdone never pulsed after the peripheral write");
        end
        repeat (4) @(posedge clk);
        if (rddone_count - rd_before != 1) begin
            report_mismatch("periph_rddone count", 32'(rddone_count - rd_before), 32'h1);
        end
        if (wren_count - wr_before != 1) begin
            report_mismatch("periph_wren count", 32'(wren_count - wr_before), 32'h1);
        end
        if (wrdone_count - wrdone_before != 1) begin
            report_mismatch("periph_wrdone count", 32'(wrdone_count - wrdone_before), 32'h1);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        reset         = 1'b1;
        addr          = '0;
        d_in          = '0;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        mreq_n        = 1'b1;
        iorq_n        = 1'b1;
        joy1_n        = 6'h3F;
        periph_rddata = periph_byte;
        cur_addr      = '0;
        ref_bank[0]   = 5'd0;
        ref_bank[1]   = 5'd1;
        ref_bank[2]   = 5'd2;
        ref_startup   = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;

        test_reset_map();
        test_bank_regs();
        test_int_ram();
        test_end_startup();
        test_io_space();

        $display("Bus cycles: %0d, errors: %0d", bus_cycles, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout after %0d ns, the bus sequence did not complete", watchdog_ns);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* all.f */
src/bus_pkg.sv
src/map_pkg.sv
src/bus_strobe_sync.sv
src/addr_decode.sv
src/bank_regs.sv
src/int_ram.sv
src/read_mux.sv
src/bus_bridge_top.sv
test/tb_bus_bridge.sv

/* Makefile */
TOP = tb_bus_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f
	verilator --lint-only --top-module bus_bridge_top src/bus_pkg.sv src/map_pkg.sv \
		src/bus_strobe_sync.sv src/addr_decode.sv src/bank_regs.sv src/int_ram.sv \
		src/read_mux.sv src/bus_bridge_top.sv

obj_dir/V$(TOP): all.f $(wildcard src/*.sv) test/tb_bus_bridge.sv
	verilator --binary --timing --top-module $(TOP) -f all.f -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
